/* include/mul_regs.svh */
// multiply accelerator register map: APB offsets and control/status bit positions
`ifndef MUL_REGS_SVH
`define MUL_REGS_SVH

// ======================================================================
// register offsets, byte addresses on the 8-bit APB address
// ======================================================================

// operand a, low WIDTH bits used
`define MUL_OFS_OPA     8'h00
// operand b, low WIDTH bits used
`define MUL_OFS_OPB     8'h04
// mode field, a write launches a multiply
`define MUL_OFS_CTRL    8'h08
// busy and done flags, read only
`define MUL_OFS_STATUS  8'h0C
// product bits 31:0, read only
`define MUL_OFS_RESLO   8'h10
// product bits above 31, zero-extended, read only
`define MUL_OFS_RESHI   8'h14

// ======================================================================
// field positions
// ======================================================================

// two-bit mode field in CTRL
`define MUL_CTRL_MODE_LSB  0
`define MUL_STAT_BUSY_BIT  0
`define MUL_STAT_DONE_BIT  1

`endif

/* rtl/mul_pkg.sv */
// multiply accelerator package: multiply mode encoding and pipeline latencies
package mul_pkg;

	// ======================================================================
	// multiply mode
	// ======================================================================

	// operand interpretation for one multiply
	// encoding 3 is reserved, the unit treats it like MUL_UU since
	// neither operand decodes as signed
	typedef enum logic [1:0] {
		// a unsigned, b unsigned
		MUL_UU = 2'd0,
		// a signed, b signed
		MUL_SS = 2'd1,
		// a signed, b unsigned
		MUL_SU = 2'd2
	} mul_mode_t;

	// ======================================================================
	// latencies
	// ======================================================================

	// partial-product pipe: sub-products, merge, final add
	localparam int PIPE_STAGES = 3;

	// unit adds one registered sign-correction stage after the pipe
	localparam int UNIT_LATENCY = PIPE_STAGES + 1;

endpackage

/* rtl/mul_pipe.sv */
// three-stage unsigned multiplier built from four half-width sub-products
module mul_pipe #(
	parameter int WIDTH = 32
) (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               in_valid,
	input  logic [WIDTH-1:0]   a,
	input  logic [WIDTH-1:0]   b,
	output logic               out_valid,
	output logic [2*WIDTH-1:0] p
);

	localparam int HALF = WIDTH / 2;

	// stage 1 sub-products, each half x half fits in WIDTH bits
	logic [WIDTH-1:0]   pp_ll;
	logic [WIDTH-1:0]   pp_lh;
	logic [WIDTH-1:0]   pp_hl;
	logic [WIDTH-1:0]   pp_hh;
	// cross terms can carry one bit past WIDTH
	logic [WIDTH:0]     cross_sum;
	// stage 2 terms
	logic [2*WIDTH-1:0] outer_q;
	logic [2*WIDTH-1:0] cross_q;
	// valid bits beside the data
	logic               v1_q;
	logic               v2_q;

	// ======================================================================
	// datapath, no reset, qualified by the valid line
	// ======================================================================

	assign cross_sum = {1'b0, pp_lh} + {1'b0, pp_hl};

	always_ff @(posedge clk) begin
		// stage 1: low x low, low x high, high x low, high x high
		pp_ll <= a[HALF-1:0] * b[HALF-1:0];
		pp_lh <= a[HALF-1:0] * b[WIDTH-1:HALF];
		pp_hl <= a[WIDTH-1:HALF] * b[HALF-1:0];
		pp_hh <= a[WIDTH-1:HALF] * b[WIDTH-1:HALF];
		// stage 2: outer products sit side by side, no overlap
		outer_q <= {pp_hh, pp_ll};
		// cross terms shifted up by half a width
		cross_q <= {{(HALF-1){1'b0}}, cross_sum, {HALF{1'b0}}};
		// stage 3: final add
		p <= outer_q + cross_q;
	end

	// ======================================================================
	// valid line, a new pair may enter every cycle
	// ======================================================================

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			v1_q      <= 1'b0;
			v2_q      <= 1'b0;
			out_valid <= 1'b0;
		end else begin
			v1_q      <= in_valid;
			v2_q      <= v1_q;
			out_valid <= v2_q;
		end
	end

endmodule

/* rtl/mul_unit.sv */
// multiply unit: unsigned partial-product pipe plus a final signed correction stage
module mul_unit #(
	parameter int WIDTH = 32
) (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               issue_valid,
	input  logic [WIDTH-1:0]   issue_a,
	input  logic [WIDTH-1:0]   issue_b,
	input  mul_pkg::mul_mode_t issue_mode,
	output logic               res_valid,
	output logic [2*WIDTH-1:0] res_product
);

	// operand interpretation for this issue
	logic               a_signed;
	logic               b_signed;
	// upper half of the correction, the lower half is always zero
	logic [WIDTH-1:0]   corr_hi;
	// correction delay line, matched to the pipe latency
	logic [WIDTH-1:0]   corr_line [mul_pkg::PIPE_STAGES];
	// unsigned product out of the pipe
	logic               pipe_valid;
	logic [2*WIDTH-1:0] pipe_p;

	// ======================================================================
	// sign correction at issue
	// ======================================================================

	// reserved mode 3 matches neither and runs unsigned
	assign a_signed = (issue_mode == mul_pkg::MUL_SS) || (issue_mode == mul_pkg::MUL_SU);
	assign b_signed = (issue_mode == mul_pkg::MUL_SS);

	// signed a = ua - 2^W * a_sign, same for b
	// the a_sign * b_sign * 2^2W term drops out modulo 2^2W
	always_comb begin
		corr_hi = '0;
		if (a_signed && issue_a[WIDTH-1])
			corr_hi = corr_hi + issue_b;
		if (b_signed && issue_b[WIDTH-1])
			corr_hi = corr_hi + issue_a;
	end

	always_ff @(posedge clk) begin
		corr_line[0] <= corr_hi;
		for (int i = 1; i < mul_pkg::PIPE_STAGES; i++) begin
			corr_line[i] <= corr_line[i-1];
		end
	end

	// ======================================================================
	// unsigned pipe
	// ======================================================================

	mul_pipe #(
		.WIDTH     (WIDTH)
	) u_pipe (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (issue_valid),
		.a         (issue_a),
		.b         (issue_b),
		.out_valid (pipe_valid),
		.p         (pipe_p)
	);

	// ======================================================================
	// final stage, subtract the delayed correction
	// ======================================================================

	always_ff @(posedge clk) begin
		res_product <= pipe_p - {corr_line[mul_pkg::PIPE_STAGES-1], {WIDTH{1'b0}}};
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			res_valid <= 1'b0;
		end else begin
			res_valid <= pipe_valid;
		end
	end

endmodule

/* rtl/mul_result_buf.sv */
// result buffer: holds the last finished product and tracks busy and done
module mul_result_buf #(
	parameter int WIDTH = 32
) (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               issue_valid,
	input  logic               res_valid,
	input  logic [2*WIDTH-1:0] res_product,
	output logic               busy,
	output logic               done,
	output logic [2*WIDTH-1:0] product
);

	// ======================================================================
	// flags
	// ======================================================================

	// only one multiply is in flight at a time, so issue and result
	// never meet on the same edge; issue still wins if they did
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy <= 1'b0;
			done <= 1'b0;
		end else if (issue_valid) begin
			busy <= 1'b1;
			done <= 1'b0;
		end else if (res_valid) begin
			busy <= 1'b0;
			done <= 1'b1;
		end
	end

	// ======================================================================
	// product register
	// ======================================================================

	// reads as zero until the first multiply finishes
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			product <= '0;
		end else if (res_valid) begin
			product <= res_product;
		end
	end

endmodule

/* rtl/mul_apb_regs.sv */
// APB register block: operand and mode registers, multiply launch, busy stall, read mux
`include "mul_regs.svh"

module mul_apb_regs #(
	parameter int WIDTH = 32
) (
	input  logic               clk,
	input  logic               rst_n,
	// APB slave
	input  logic [7:0]         paddr,
	input  logic               psel,
	input  logic               penable,
	input  logic               pwrite,
	input  logic [31:0]        pwdata,
	output logic [31:0]        prdata,
	output logic               pready,
	output logic               pslverr,
	// from the result buffer
	input  logic               busy,
	input  logic               done,
	input  logic [2*WIDTH-1:0] product,
	// launch towards the multiply unit
	output logic               issue_valid,
	output logic [WIDTH-1:0]   issue_a,
	output logic [WIDTH-1:0]   issue_b,
	output mul_pkg::mul_mode_t issue_mode
);

	// access phase of a transfer
	logic               access;
	// address decode
	logic               addr_ok;
	logic               addr_ro;
	logic               ctrl_hit;
	// completed writes that change state
	logic               wr_done;
	logic               ctrl_done;
	// held registers
	logic [WIDTH-1:0]   opa_q;
	logic [WIDTH-1:0]   opb_q;
	mul_pkg::mul_mode_t mode_q;
	// product padded to two full bus words
	logic [63:0]        prod_ext;

	// ======================================================================
	// decode
	// ======================================================================

	assign access   = psel & penable;
	assign ctrl_hit = (paddr == `MUL_OFS_CTRL);

	always_comb begin
		case (paddr)
			`MUL_OFS_OPA, `MUL_OFS_OPB, `MUL_OFS_CTRL: begin
				addr_ok = 1'b1;
				addr_ro = 1'b0;
			end
			`MUL_OFS_STATUS, `MUL_OFS_RESLO, `MUL_OFS_RESHI: begin
				addr_ok = 1'b1;
				addr_ro = 1'b1;
			end
			default: begin
				addr_ok = 1'b0;
				addr_ro = 1'b0;
			end
		endcase
	end

	// hold a CTRL write in its access phase until the previous product lands
	assign pready  = ~(access & pwrite & ctrl_hit & busy);
	// unknown offset, or a write to a read-only register
	assign pslverr = access & (~addr_ok | (pwrite & addr_ro));

	assign wr_done   = access & pready & pwrite & addr_ok & ~addr_ro;
	assign ctrl_done = wr_done & ctrl_hit;

	// ======================================================================
	// registers
	// ======================================================================

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			opa_q  <= '0;
			opb_q  <= '0;
			mode_q <= mul_pkg::MUL_UU;
		end else if (wr_done) begin
			case (paddr)
				`MUL_OFS_OPA:  opa_q  <= pwdata[WIDTH-1:0];
				`MUL_OFS_OPB:  opb_q  <= pwdata[WIDTH-1:0];
				`MUL_OFS_CTRL: mode_q <= mul_pkg::mul_mode_t'(pwdata[`MUL_CTRL_MODE_LSB +: 2]);
				default:       opa_q  <= opa_q;
			endcase
		end
	end

	// one pulse per completed CTRL write, operands are stable while it is high
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			issue_valid <= 1'b0;
		end else begin
			issue_valid <= ctrl_done;
		end
	end

	assign issue_a    = opa_q;
	assign issue_b    = opb_q;
	assign issue_mode = mode_q;

	// ======================================================================
	// read mux
	// ======================================================================

	// RESHI is zero when the product fits in one word
	assign prod_ext = 64'(product);

	always_comb begin
		prdata = '0;
		case (paddr)
			`MUL_OFS_OPA:    prdata = 32'(opa_q);
			`MUL_OFS_OPB:    prdata = 32'(opb_q);
			`MUL_OFS_CTRL:   prdata[`MUL_CTRL_MODE_LSB +: 2] = mode_q;
			`MUL_OFS_STATUS: begin
				prdata[`MUL_STAT_BUSY_BIT] = busy;
				prdata[`MUL_STAT_DONE_BIT] = done;
			end
			`MUL_OFS_RESLO:  prdata = prod_ext[31:0];
			`MUL_OFS_RESHI:  prdata = prod_ext[63:32];
			default:         prdata = '0;
		endcase
	end

endmodule

/* rtl/mul_apb_top.sv */
// multiply accelerator top: APB register block, multiply unit and result buffer
module mul_apb_top #(
	// operand width, even and at most the 32-bit bus width
	parameter int WIDTH = 32
) (
	input  logic        clk,
	input  logic        rst_n,
	input  logic [7:0]  paddr,
	input  logic        psel,
	input  logic        penable,
	input  logic        pwrite,
	input  logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic        pready,
	output logic        pslverr
);

	// register block to unit
	logic               issue_valid;
	logic [WIDTH-1:0]   issue_a;
	logic [WIDTH-1:0]   issue_b;
	mul_pkg::mul_mode_t issue_mode;
	// unit to result buffer
	logic               res_valid;
	logic [2*WIDTH-1:0] res_product;
	// result buffer back to register block
	logic               busy;
	logic               done;
	logic [2*WIDTH-1:0] product;

	// ======================================================================
	// input side
	// ======================================================================

	mul_apb_regs #(
		.WIDTH       (WIDTH)
	) u_regs (
		.clk         (clk),
		.rst_n       (rst_n),
		.paddr       (paddr),
		.psel        (psel),
		.penable     (penable),
		.pwrite      (pwrite),
		.pwdata      (pwdata),
		.prdata      (prdata),
		.pready      (pready),
		.pslverr     (pslverr),
		.busy        (busy),
		.done        (done),
		.product     (product),
		.issue_valid (issue_valid),
		.issue_a     (issue_a),
		.issue_b     (issue_b),
		.issue_mode  (issue_mode)
	);

	// ======================================================================
	// processing and output side
	// ======================================================================

	mul_unit #(
		.WIDTH       (WIDTH)
	) u_unit (
		.clk         (clk),
		.rst_n       (rst_n),
		.issue_valid (issue_valid),
		.issue_a     (issue_a),
		.issue_b     (issue_b),
		.issue_mode  (issue_mode),
		.res_valid   (res_valid),
		.res_product (res_product)
	);

	mul_result_buf #(
		.WIDTH       (WIDTH)
	) u_res (
		.clk         (clk),
		.rst_n       (rst_n),
		.issue_valid (issue_valid),
		.res_valid   (res_valid),
		.res_product (res_product),
		.busy        (busy),
		.done        (done),
		.product     (product)
	);

endmodule

/* dv/mul_tb.sv */
// testbench for the APB multiply accelerator covering products, status flags, busy stall and bus errors
`include "mul_regs.svh"

module mul_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int WIDTH     = 32;
	localparam int SEED      = 73911;
	localparam int N_PAIRS   = 7;
	localparam int N_RANDOM  = 40;
	// edges from a completed CTRL write until STATUS reads done
	localparam int DONE_EDGES = 6;
	// reset, flags, stall, its two products, address errors
	localparam int NUM_TESTS = 6 + 3 * N_PAIRS + N_RANDOM;
	// per-test allowance doubled over all tests
	localparam int CYCLE_LIMIT = NUM_TESTS * (mul_pkg::UNIT_LATENCY + 20) * 2;

	logic        clk;
	logic        rst_n;
	logic [7:0]  paddr;
	logic        psel;
	logic        penable;
	logic        pwrite;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic        pready;
	logic        pslverr;

	int cycles;
	int errors;
	int tests_run;
	int tests_failed;

	// products waiting for the compare process
	logic [2*WIDTH-1:0] exp_q [$];
	logic [2*WIDTH-1:0] act_q [$];
	string              name_q [$];

	// directed operand pairs
	logic [WIDTH-1:0] pair_a [N_PAIRS];
	logic [WIDTH-1:0] pair_b [N_PAIRS];

	mul_apb_top #(
		.WIDTH   (WIDTH)
	) UUT (
		.clk     (clk),
		.rst_n   (rst_n),
		.paddr   (paddr),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.pwdata  (pwdata),
		.prdata  (prdata),
		.pready  (pready),
		.pslverr (pslverr)
	);

	initial clk = 1'b0;
	always #50 clk = ~clk;

	// ======================================================================
	// reference model and compare tasks
	// ======================================================================

	// extend each operand per mode then multiply at full width
	function automatic logic [2*WIDTH-1:0] ref_product(input logic [WIDTH-1:0] a,
			input logic [WIDTH-1:0] b, input mul_pkg::mul_mode_t mode);
		logic [2*WIDTH-1:0] ea;
		logic [2*WIDTH-1:0] eb;
		ea = {{WIDTH{1'b0}}, a};
		eb = {{WIDTH{1'b0}}, b};
		if (mode == mul_pkg::MUL_SS || mode == mul_pkg::MUL_SU)
			ea = {{WIDTH{a[WIDTH-1]}}, a};
		if (mode == mul_pkg::MUL_SS)
			eb = {{WIDTH{b[WIDTH-1]}}, b};
		return ea * eb;
	endfunction

	task automatic check_product(input string name, input logic [2*WIDTH-1:0] expv,
			input logic [2*WIDTH-1:0] actv, inout int errs);
		if (actv !== expv) begin
			errs++;
			errors++;
			$display("ERR %s expected %h actual %h", name, expv, actv);
		end
	endtask

	task automatic check_word(input string name, input logic [31:0] expv,
			input logic [31:0] actv, inout int errs);
		if (actv !== expv) begin
			errs++;
			errors++;
			$display("ERR %s expected %h actual %h", name, expv, actv);
		end
	endtask

	task automatic check_flag(input string name, input logic expv, input logic actv,
			inout int errs);
		if (actv !== expv) begin
			errs++;
			errors++;
			$display("ERR %s expected %b actual %b", name, expv, actv);
		end
	endtask

	// one line per finished test
	task automatic finish_test(input string name, input int errs);
		tests_run++;
		if (errs == 0) begin
			$display("ok   %s", name);
		end else begin
			tests_failed++;
			$display("bad  %s (%0d mismatches)", name, errs);
		end
	endtask

	// compares products on the falling edge away from the stimulus updates
	always @(negedge clk) begin
		int                 errs;
		string              nm;
		logic [2*WIDTH-1:0] ev;
		logic [2*WIDTH-1:0] av;
		while (act_q.size() != 0) begin
			errs = 0;
			nm = name_q.pop_front();
			ev = exp_q.pop_front();
			av = act_q.pop_front();
			check_product(nm, ev, av, errs);
			finish_test(nm, errs);
		end
	end

	// run limit
	always @(posedge clk) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout: run still going after %0d cycles", CYCLE_LIMIT);
			$display("Simulation FAILED");
			$finish;
		end
	end

	// ======================================================================
	// APB tasks called 1 ns after a rising edge
	// ======================================================================

	task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
			output logic [31:0] rdata, output logic err, output int stall);
		logic rdy;
		stall = 0;
		rdy = 1'b0;
		rdata = '0;
		err = 1'b0;
		// setup phase
		psel = 1'b1;
		penable = 1'b0;
		pwrite = wr;
		paddr = addr;
		pwdata = wdata;
		@(posedge clk);
		#1;
		penable = 1'b1;
		// access phase sampled mid-cycle where the slave outputs are settled
		while (!rdy) begin
			@(negedge clk);
			rdy = pready;
			rdata = prdata;
			err = pslverr;
			if (!rdy)
				stall++;
			@(posedge clk);
			#1;
		end
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic apb_write(input logic [7:0] addr, input logic [31:0] data,
			output logic err, output int stall);
		logic [31:0] rd_unused;
		apb_xfer(1'b1, addr, data, rd_unused, err, stall);
	endtask

	task automatic apb_read(input logic [7:0] addr, output logic [31:0] data, output logic err);
		int stall;
		apb_xfer(1'b0, addr, 32'h0, data, err, stall);
	endtask

	// ======================================================================
	// multiply sequences
	// ======================================================================

	task automatic launch(input logic [WIDTH-1:0] a, input logic [WIDTH-1:0] b,
			input logic [1:0] mode_bits);
		logic err;
		int   stall;
		apb_write(`MUL_OFS_OPA, 32'(a), err, stall);
		apb_write(`MUL_OFS_OPB, 32'(b), err, stall);
		apb_write(`MUL_OFS_CTRL, 32'(mode_bits) << `MUL_CTRL_MODE_LSB, err, stall);
	endtask

	task automatic poll_done();
		logic [31:0] st;
		logic        err;
		st = '0;
		while (!st[`MUL_STAT_DONE_BIT])
			apb_read(`MUL_OFS_STATUS, st, err);
	endtask

	task automatic read_product(output logic [2*WIDTH-1:0] p);
		logic [31:0] lo;
		logic [31:0] hi;
		logic        err;
		apb_read(`MUL_OFS_RESLO, lo, err);
		apb_read(`MUL_OFS_RESHI, hi, err);
		p = (2*WIDTH)'({hi, lo});
	endtask

	task automatic queue_result(input string name, input logic [2*WIDTH-1:0] expv,
			input logic [2*WIDTH-1:0] actv);
		name_q.push_back(name);
		exp_q.push_back(expv);
		act_q.push_back(actv);
	endtask

	// reserved mode 3 is expected to run unsigned
	task automatic run_product(input string name, input logic [WIDTH-1:0] a,
			input logic [WIDTH-1:0] b, input logic [1:0] mode_bits);
		mul_pkg::mul_mode_t m;
		logic [2*WIDTH-1:0] expv;
		logic [2*WIDTH-1:0] actv;
		m = (mode_bits == 2'd3) ? mul_pkg::MUL_UU : mul_pkg::mul_mode_t'(mode_bits);
		expv = ref_product(a, b, m);
		launch(a, b, mode_bits);
		poll_done();
		read_product(actv);
		queue_result(name, expv, actv);
	endtask

	// ======================================================================
	// main sequence
	// ======================================================================

	initial begin
		logic [31:0]        rd;
		logic               err;
		int                 stall;
		int                 errs;
		logic [WIDTH-1:0]   ra;
		logic [WIDTH-1:0]   rb;
		logic [1:0]         rm;
		logic [2*WIDTH-1:0] exp1;
		logic [2*WIDTH-1:0] exp2;
		logic [2*WIDTH-1:0] p;

		void'($urandom(SEED));
		rst_n = 1'b0;
		paddr = '0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		pwdata = '0;
		cycles = 0;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;

		// corner operands zero, one, all ones and most negative plus the reference pair
		pair_a[0] = '0;
		pair_b[0] = '1;
		pair_a[1] = WIDTH'(1);
		pair_b[1] = '1;
		pair_a[2] = '1;
		pair_b[2] = '1;
		pair_a[3] = {1'b1, {(WIDTH-1){1'b0}}};
		pair_b[3] = WIDTH'(1);
		pair_a[4] = {1'b1, {(WIDTH-1){1'b0}}};
		pair_b[4] = {1'b1, {(WIDTH-1){1'b0}}};
		pair_a[5] = {1'b1, {(WIDTH-1){1'b0}}};
		pair_b[5] = '1;
		pair_a[6] = WIDTH'(112345678);
		pair_b[6] = WIDTH'(987654321);

		repeat (5) @(posedge clk);
		#1;
		rst_n = 1'b1;
		@(posedge clk);
		#1;

		// reset state
		errs = 0;
		apb_read(`MUL_OFS_STATUS, rd, err);
		check_flag("reset_state busy", 1'b0, rd[`MUL_STAT_BUSY_BIT], errs);
		check_flag("reset_state done", 1'b0, rd[`MUL_STAT_DONE_BIT], errs);
		check_flag("reset_state pslverr", 1'b0, err, errs);
		apb_read(`MUL_OFS_RESLO, rd, err);
		check_word("reset_state reslo", 32'h0, rd, errs);
		apb_read(`MUL_OFS_RESHI, rd, err);
		check_word("reset_state reshi", 32'h0, rd, errs);
		finish_test("reset_state", errs);

		// directed corners in all three modes
		for (int i = 0; i < N_PAIRS; i++) begin
			for (int m = 0; m < 3; m++) begin
				run_product($sformatf("dir_%0d_mode%0d", i, m), pair_a[i], pair_b[i], 2'(m));
			end
		end

		// random pairs with the reserved mode included
		for (int i = 0; i < N_RANDOM; i++) begin
			ra = WIDTH'($urandom());
			rb = WIDTH'($urandom());
			rm = 2'($urandom_range(0, 3));
			run_product($sformatf("rand_%0d_mode%0d", i, rm), ra, rb, rm);
		end

		// status flags around one multiply
		errs = 0;
		launch(WIDTH'(32'h0001_2345), WIDTH'(32'hfedc_ba98), 2'(mul_pkg::MUL_SS));
		apb_read(`MUL_OFS_STATUS, rd, err);
		check_flag("status_flags busy at issue", 1'b1, rd[`MUL_STAT_BUSY_BIT], errs);
		check_flag("status_flags done at issue", 1'b0, rd[`MUL_STAT_DONE_BIT], errs);
		poll_done();
		apb_read(`MUL_OFS_STATUS, rd, err);
		check_flag("status_flags busy after", 1'b0, rd[`MUL_STAT_BUSY_BIT], errs);
		check_flag("status_flags done after", 1'b1, rd[`MUL_STAT_DONE_BIT], errs);
		// STATUS access completing 6 edges after the CTRL write
		launch(WIDTH'(7), WIDTH'(9), 2'(mul_pkg::MUL_UU));
		repeat (DONE_EDGES - 2) @(posedge clk);
		#1;
		apb_read(`MUL_OFS_STATUS, rd, err);
		check_flag("status_flags done at 6 edges", 1'b1, rd[`MUL_STAT_DONE_BIT], errs);
		finish_test("status_flags", errs);

		// back-to-back CTRL writes where the second waits for the first product
		errs = 0;
		ra = WIDTH'(32'h8765_4321);
		rb = WIDTH'(32'h0abc_def1);
		exp1 = ref_product(ra, rb, mul_pkg::MUL_SU);
		exp2 = ref_product(ra, rb, mul_pkg::MUL_SS);
		launch(ra, rb, 2'(mul_pkg::MUL_SU));
		apb_write(`MUL_OFS_CTRL, 32'(mul_pkg::MUL_SS) << `MUL_CTRL_MODE_LSB, err, stall);
		// the stalled write completes on the edge where STATUS first reads done
		check_word("busy_stall stall cycles", 32'(DONE_EDGES - 2), 32'(stall), errs);
		check_flag("busy_stall pslverr", 1'b0, err, errs);
		// the first product is still held until after these two reads
		read_product(p);
		queue_result("busy_stall first", exp1, p);
		poll_done();
		read_product(p);
		queue_result("busy_stall second", exp2, p);
		finish_test("busy_stall", errs);

		// bad offset and a write to a read-only register
		errs = 0;
		apb_read(8'h18, rd, err);
		check_flag("addr_error read 0x18", 1'b1, err, errs);
		apb_write(`MUL_OFS_RESLO, 32'hdead_beef, err, stall);
		check_flag("addr_error write reslo", 1'b1, err, errs);
		apb_read(`MUL_OFS_RESLO, rd, err);
		check_word("addr_error reslo kept", exp2[31:0], rd, errs);
		check_flag("addr_error reslo pslverr", 1'b0, err, errs);
		finish_test("addr_error", errs);

		// let the compare process drain
		repeat (2) @(posedge clk);
		if (tests_run != NUM_TESTS)
			$display("only %0d of %0d tests reported a result", tests_run, NUM_TESTS);
		$display("tests %0d, failed %0d, mismatches %0d", tests_run, tests_failed, errors);
		if (errors == 0 && tests_run == NUM_TESTS) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

/* mul_apb_top.f */
+incdir+include
rtl/mul_pkg.sv
rtl/mul_pipe.sv
rtl/mul_unit.sv
rtl/mul_result_buf.sv
rtl/mul_apb_regs.sv
rtl/mul_apb_top.sv
dv/mul_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the multiply accelerator testbench with Verilator.
# Exits non-zero if the build or the run fails, or if the pass line is missing.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal \
	--top-module mul_tb \
	-f mul_apb_top.f \
	-Mdir obj_dir \
	-o mul_sim
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

sim_out=$(./obj_dir/mul_sim)
status=$?
printf '%s\n' "$sim_out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$sim_out" | grep -q '^Simulation PASSED$'; then
	exit 0
fi
exit 1
